// ==== hw/stream_fifo.sv ====
// small stream FIFO with valid/busy on both sides
// circular buffer, busy only when full, payload type set per instance

`timescale 1ns/1ns

module stream_fifo #(
   parameter type payload_t = zle_pkg::zle_word_t
) (
   input  logic     clock,
   input  logic     reset,
   input  logic     i_valid,
   input  payload_t i_data,
   input  logic     i_busy,
   output logic     o_busy,
   output logic     o_valid,
   output payload_t o_data
);
   import zle_pkg::*;

   typedef logic [$clog2(FIFO_DEPTH)-1:0]   ptr_t;
   typedef logic [$clog2(FIFO_DEPTH+1)-1:0] count_t;

   payload_t mem [FIFO_DEPTH];
   ptr_t     rd_ptr;
   ptr_t     wr_ptr;
   count_t   count;
   logic     push;
   logic     pop;

   function automatic ptr_t next_ptr(input ptr_t ptr);
      next_ptr = (ptr == ptr_t'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign o_busy  = (count == count_t'(FIFO_DEPTH));
   assign o_valid = (count != '0);
   assign o_data  = mem[rd_ptr];

   assign push = i_valid & ~o_busy;
   assign pop  = o_valid & ~i_busy;

   always_ff @(posedge clock) begin
      if (push) begin
         mem[wr_ptr] <= i_data;
      end
   end

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= next_ptr(wr_ptr);
         if (pop)  rd_ptr <= next_ptr(rd_ptr);
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // none, or both at once
         endcase
      end
   end

endmodule

// ==== hw/zle_datapath.sv ====
// zero run-length encoder datapath
// holds the taken word and the run counter, raises the zero and
// full-run flags and selects the token for the current state

`timescale 1ns/1ns

module zle_datapath (
   input  logic                clock,
   input  logic                reset,
   input  zle_pkg::zle_state_e i_state,
   input  logic                i_pop,
   input  zle_pkg::zle_word_t  i_word,    // input fifo head
   output zle_pkg::zle_flags_t o_flags,
   output zle_pkg::zle_token_t o_token
);
   import zle_pkg::*;

   zle_word_t        word_q;
   logic [CNT_W-1:0] cnt_q;   // run length minus one
   zle_word_t        run_len;

   // word taken from the fifo
   always_ff @(posedge clock) begin
      if (i_pop) begin
         word_q <= i_word;
      end
   end

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         cnt_q <= '0;
      end else begin
         case (i_state)
            st_start_t:   cnt_q <= '0;             // first zero of a run
            st_zeros_t_t: cnt_q <= '0;             // 17th zero opens a new run
            st_zeros_t_e: cnt_q <= cnt_q + 1'b1;
            default:      cnt_q <= cnt_q;
         endcase
      end
   end

   assign run_len = zle_word_t'(cnt_q) + zle_word_t'(1);

   // flags look at the head before it is taken
   assign o_flags.in_eq_0   = (i_word == '0);
   assign o_flags.cnt_eq_15 = (cnt_q == CNT_W'(RUN_MAX - 1));

   // token select by state
   always_comb begin
      case (i_state)
         st_zeros_e: begin
            o_token.is_run = 1'b1;
            o_token.value  = run_len;
         end
         st_zeros_t_t: begin
            o_token.is_run = 1'b1;
            o_token.value  = zle_word_t'(RUN_MAX);
         end
         default: begin
            // literal, used by st_start_e and st_pending
            o_token.is_run = 1'b0;
            o_token.value  = word_q;
         end
      endcase
   end

endmodule

// ==== hw/zle_fsm.sv ====
// zero run-length encoder control FSM
// nine-state graph with an explicit fire per state
// drives the datapath through its state and takes back its flags

`timescale 1ns/1ns

module zle_fsm (
   input  logic                clock,
   input  logic                reset,
   input  logic                i_valid,   // input fifo not empty
   input  logic                i_busy,    // output fifo full
   input  zle_pkg::zle_flags_t i_flags,
   output logic                o_busy,
   output logic                o_valid,
   output logic                o_pop,
   output logic                o_push,
   output zle_pkg::zle_state_e o_state
);
   import zle_pkg::*;

   zle_state_e state;
   zle_state_e state_d;
   logic       fire;
   logic       pop;
   logic       push;

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         state <= st_start;
      end else begin
         state <= state_d;
      end
   end

   // fire condition of each state
   always_comb begin
      case (state)
         st_start:     fire = i_valid;    // take a word
         st_start_t:   fire = 1'b1;
         st_start_e:   fire = ~i_busy;    // emit literal
         st_zeros:     fire = i_valid;
         st_zeros_t:   fire = 1'b1;
         st_zeros_t_t: fire = ~i_busy;
         st_zeros_t_e: fire = 1'b1;
         st_zeros_e:   fire = ~i_busy;
         st_pending:   fire = ~i_busy;
         default:      fire = 1'b1;       // leave an illegal state
      endcase
   end

   // a state that does not fire holds
   always_comb begin
      state_d = state;
      pop     = 1'b0;
      push    = 1'b0;
      if (fire) begin
         case (state)
            st_start: begin
               pop = 1'b1;
               if (i_flags.in_eq_0) begin
                  state_d = st_start_t;
               end else begin
                  state_d = st_start_e;
               end
            end
            st_start_t: begin
               state_d = st_zeros;   // counter cleared here
            end
            st_start_e: begin
               push    = 1'b1;
               state_d = st_start;
            end
            st_zeros: begin
               pop = 1'b1;
               if (i_flags.in_eq_0) begin
                  state_d = st_zeros_t;
               end else begin
                  state_d = st_zeros_e;
               end
            end
            st_zeros_t: begin
               if (i_flags.cnt_eq_15) begin
                  state_d = st_zeros_t_t;
               end else begin
                  state_d = st_zeros_t_e;
               end
            end
            st_zeros_t_t: begin
               push    = 1'b1;   // run of 16 while the next run has begun
               state_d = st_zeros;
            end
            st_zeros_t_e: begin
               state_d = st_zeros;
            end
            st_zeros_e: begin
               push    = 1'b1;
               state_d = st_pending;
            end
            st_pending: begin
               push    = 1'b1;   // literal that closed the run
               state_d = st_start;
            end
            default: begin
               state_d = st_start;
            end
         endcase
      end
   end

   assign o_pop   = pop;
   assign o_busy  = ~pop;
   assign o_push  = push;
   assign o_valid = push;
   assign o_state = state;

endmodule

// ==== hw/zle_pkg.sv ====
// zero run-length encoder shared definitions
// word and token formats, controller states and datapath flags

package zle_pkg;

   localparam int WORD_W     = 16;   // data word width
   localparam int CNT_W      = 4;    // run counter holds length minus one
   localparam int RUN_MAX    = 16;   // longest run in a single token
   localparam int FIFO_DEPTH = 4;    // entries per stream fifo

   typedef logic [WORD_W-1:0] zle_word_t;

   // output token with a literal word or a run length 1..16
   typedef struct packed {
      logic      is_run;
      zle_word_t value;
   } zle_token_t;

   // encoder states of the nine-state graph
   typedef enum logic [3:0] {
      st_start     = 4'd0,
      st_start_t   = 4'd1,   // first zero of a run taken
      st_start_e   = 4'd2,   // literal waiting to leave
      st_zeros     = 4'd3,
      st_zeros_t   = 4'd4,
      st_zeros_t_t = 4'd5,   // full run of 16 leaves
      st_zeros_t_e = 4'd6,
      st_zeros_e   = 4'd7,   // run ended by a literal
      st_pending   = 4'd8    // literal after run token
   } zle_state_e;

   // datapath to controller
   typedef struct packed {
      logic in_eq_0;     // fifo head is zero
      logic cnt_eq_15;   // 16 zeros already counted
   } zle_flags_t;

endpackage

// ==== hw/zle_top.sv ====
// zero run-length encoder top level
// input FIFO, control FSM with its datapath, output token FIFO

`timescale 1ns/1ns

module zle_top (
   input  logic                clock,
   input  logic                reset,
   input  logic                i_valid,
   input  zle_pkg::zle_word_t  i_word,
   input  logic                i_busy,
   output logic                o_busy,
   output logic                o_valid,
   output zle_pkg::zle_token_t o_token
);
   import zle_pkg::*;

   logic       head_valid;   // input fifo not empty
   zle_word_t  head_word;
   logic       fsm_busy;     // low when the fsm pops
   logic       fsm_valid;
   logic       fsm_pop;
   logic       out_full;
   zle_state_e state;
   zle_flags_t flags;
   zle_token_t token;

   stream_fifo #(.payload_t(zle_word_t)) in_fifo (
      .clock   (clock),
      .reset   (reset),
      .i_valid (i_valid),
      .i_data  (i_word),
      .i_busy  (fsm_busy),
      .o_busy  (o_busy),
      .o_valid (head_valid),
      .o_data  (head_word)
   );

   zle_fsm u_fsm (
      .clock   (clock),
      .reset   (reset),
      .i_valid (head_valid),
      .i_busy  (out_full),
      .i_flags (flags),
      .o_busy  (fsm_busy),
      .o_valid (fsm_valid),
      .o_pop   (fsm_pop),
      .o_push  (),            // same strobe as o_valid
      .o_state (state)
   );

   zle_datapath u_dp (
      .clock   (clock),
      .reset   (reset),
      .i_state (state),
      .i_pop   (fsm_pop),
      .i_word  (head_word),
      .o_flags (flags),
      .o_token (token)
   );

   stream_fifo #(.payload_t(zle_token_t)) out_fifo (
      .clock   (clock),
      .reset   (reset),
      .i_valid (fsm_valid),
      .i_data  (token),
      .i_busy  (i_busy),
      .o_busy  (out_full),
      .o_valid (o_valid),
      .o_data  (o_token)
   );

endmodule

// ==== list.f ====
hw/zle_pkg.sv
hw/stream_fifo.sv
hw/zle_fsm.sv
hw/zle_datapath.sv
hw/zle_top.sv
test/zle_properties.sv
test/zle_tb.sv

// ==== test/zle_properties.sv ====
// handshake and reset properties of the zero run-length encoder
// bound into zle_top, watches both stream ports

`timescale 1ns/1ns

module zle_properties (
   input logic                clock,
   input logic                reset,
   input logic                i_word_valid,    // top i_valid
   input logic                i_word_busy,     // top o_busy
   input logic                i_token_valid,   // top o_valid
   input logic                i_token_busy,    // top i_busy
   input zle_pkg::zle_token_t i_token
);
   int fail_count = 0;

   // both streams quiet while in reset
   reset_quiet: assert property (@(posedge clock)
      !reset |-> !i_token_valid && !i_word_busy)
      else begin
         fail_count++;
         $error("o_valid or o_busy high during reset");
      end

   reset_exit: assert property (@(posedge clock)
      $rose(reset) |-> !i_token_valid && !i_word_busy)
      else begin
         fail_count++;
         $error("o_valid or o_busy high in the first cycle after reset");
      end

   // token held while downstream is busy
   token_hold: assert property (@(posedge clock) disable iff (!reset)
      i_token_valid && i_token_busy |=> i_token_valid && $stable(i_token))
      else begin
         fail_count++;
         $error("o_token changed or dropped while i_busy was high");
      end

   // busy only once the input fifo was full or just filled
   busy_cause: assert property (@(posedge clock) disable iff (!reset)
      i_word_busy |-> $past(i_word_busy) || $past(i_word_valid))
      else begin
         fail_count++;
         $error("o_busy rose without the input fifo filling");
      end

endmodule

bind zle_top zle_properties u_props (
   .clock         (clock),
   .reset         (reset),
   .i_word_valid  (i_valid),
   .i_word_busy   (o_busy),
   .i_token_valid (o_valid),
   .i_token_busy  (i_busy),
   .i_token       (o_token)
);

// ==== test/zle_tb.sv ====
// testbench for the zero run-length encoder
// directed and random word streams with tokens checked against a model queue

`timescale 1ns/1ns

module zle_tb;
   import zle_pkg::*;

   localparam int clk_period = 8;
   localparam int n_words    = 20 + 152 + 92 + 441 + 8;   // upper bound of words sent

   logic        clock = 1'b0;
   logic        reset;
   logic        i_valid;
   zle_word_t   i_word;
   logic        i_busy;
   logic        o_busy;
   logic        o_valid;
   zle_token_t  o_token;

   zle_token_t  exp_q[$];   // expected tokens in order
   zle_token_t  exp_tok;
   logic [31:0] stim_state   = 32'd13960;
   logic [31:0] busy_state   = 32'd13960;
   int          zero_count   = 0;   // zeros held back by the model
   int          errors       = 0;
   int          tokens_seen  = 0;
   int          tests_passed = 0;
   int          tests_failed = 0;
   logic        random_busy  = 1'b0;
   logic        busy_seen    = 1'b0;

   zle_top uut (
      .clock   (clock),
      .reset   (reset),
      .i_valid (i_valid),
      .i_word  (i_word),
      .i_busy  (i_busy),
      .o_busy  (o_busy),
      .o_valid (o_valid),
      .o_token (o_token)
   );

   always #(clk_period / 2) clock = ~clock;

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [31:0] next_rand();
      stim_state = lcg_step(stim_state);
      return stim_state;
   endfunction

   function automatic zle_word_t next_literal();
      zle_word_t w;
      w = zle_word_t'(next_rand() >> 16);
      return (w == '0) ? zle_word_t'(1) : w;   // literals are never zero
   endfunction

   function automatic int total_errors();
      return errors + uut.u_props.fail_count;
   endfunction

   // reference encoder taking one word at a time
   task automatic model_word(input zle_word_t w);
      if (w == '0) begin
         if (zero_count == RUN_MAX) begin
            exp_q.push_back('{is_run: 1'b1, value: zle_word_t'(RUN_MAX)});
            zero_count = 1;   // 17th zero opens the next run
         end else begin
            zero_count++;
         end
      end else begin
         if (zero_count != 0) begin
            exp_q.push_back('{is_run: 1'b1, value: zle_word_t'(zero_count)});
         end
         zero_count = 0;
         exp_q.push_back('{is_run: 1'b0, value: w});
      end
   endtask

   task automatic send_word(input zle_word_t w);
      model_word(w);
      i_valid <= 1'b1;
      i_word  <= w;
      @(posedge clock);
      while (o_busy) @(posedge clock);   // held until the input fifo takes it
   endtask

   task automatic send_zeros(input int n);
      repeat (n) send_word('0);
   endtask

   task automatic drain_output();
      i_valid <= 1'b0;
      while (exp_q.size() != 0) @(posedge clock);
      repeat (4) @(posedge clock);   // room for a stray extra token
   endtask

   task automatic report_test(input string name, input int mark);
      if (total_errors() == mark) begin
         tests_passed++;
         $display("%s: ok", name);
      end else begin
         tests_failed++;
         $display("%s: %0d errors", name, total_errors() - mark);
      end
   endtask

   always @(posedge clock) begin
      busy_state <= lcg_step(busy_state);
      i_busy     <= random_busy & busy_state[24];
      if (o_busy) busy_seen <= 1'b1;
   end

   // output monitor with one check per token transfer
   always @(posedge clock) begin
      if (reset && o_valid && !i_busy) begin
         tokens_seen++;
         if (exp_q.size() == 0) begin
            $display("token %h left at %0t ns with nothing expected", o_token, $time);
            errors++;
         end else begin
            exp_tok = exp_q.pop_front();
            assert (o_token == exp_tok) else begin
               $display("[FAIL] %0t ns o_token expected %h got %h", $time, exp_tok, o_token);
               errors++;
            end
         end
      end
   end

   initial begin
      #(clk_period * (20 * n_words + 2000));
      $display("watchdog expired, the encoder stopped making progress");
      $display("Regression failed");
      $finish;
   end

   initial begin
      int mark;
      int held;
      int len;
      int sent;
      int long_runs[3];
      long_runs = '{17, 32, 40};
      reset   = 1'b0;
      i_valid = 1'b0;
      i_word  = '0;
      i_busy  = 1'b0;
      repeat (10) @(posedge clock);
      reset <= 1'b1;
      @(posedge clock);
      mark = total_errors();
      assert (!o_valid && !o_busy) else begin
         $display("o_valid or o_busy high right after reset");
         errors++;
      end
      report_test("reset state", mark);

      mark = total_errors();
      repeat (20) send_word(next_literal());
      drain_output();
      report_test("literals", mark);

      mark = total_errors();
      for (len = 1; len <= RUN_MAX; len++) begin
         send_zeros(len);
         send_word(next_literal());
      end
      drain_output();
      report_test("short runs", mark);

      mark = total_errors();
      foreach (long_runs[i]) begin
         send_zeros(long_runs[i]);   // split into tokens of 16
         send_word(next_literal());
      end
      drain_output();
      report_test("long runs", mark);

      mark = total_errors();
      random_busy = 1'b1;
      busy_seen   = 1'b0;
      sent        = 0;
      while (sent < 400) begin
         len = next_rand() % 41;
         send_zeros(len);
         send_word(next_literal());
         sent += len + 1;
      end
      drain_output();
      random_busy = 1'b0;
      assert (busy_seen) else begin
         $display("o_busy never rose under downstream back-pressure");
         errors++;
      end
      report_test("random back-pressure", mark);

      mark = total_errors();
      send_zeros(7);
      i_valid <= 1'b0;
      held = tokens_seen;
      repeat (100) @(posedge clock);
      assert (tokens_seen == held) else begin
         $display("a token left while trailing zeros had no ending literal");
         errors++;
      end
      send_word(next_literal());   // releases the held run
      drain_output();
      report_test("trailing zeros", mark);

      $display("tests: %0d passed, %0d failed", tests_passed, tests_failed);
      if (tests_failed == 0 && total_errors() == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule
